//--- bench/mem_stim.txt
// op addr data funct3 expect_a expect_b m_ar_count_delta
// op: 0 fetch, 1 load, 2 store, 3 fence.i, 4 timer load, 5 fetch with load at data
0 00000040 00000000 0 a5a50010 00000000 1
0 00000040 00000000 0 a5a50010 00000000 0
2 00000040 12345678 2 00000000 00000000 0
0 00000040 00000000 0 a5a50010 00000000 0
3 00000000 00000000 0 00000000 00000000 0
0 00000040 00000000 0 12345678 00000000 1
1 00000710 00000000 0 ffffffc4 00000000 1
1 00000710 00000000 4 000000c4 00000000 1
1 00000711 00000000 0 00000001 00000000 1
1 00000712 00000000 0 ffffffa5 00000000 1
1 00000713 00000000 4 000000a5 00000000 1
1 00000710 00000000 1 000001c4 00000000 1
1 00000712 00000000 1 ffffa5a5 00000000 1
1 00000712 00000000 5 0000a5a5 00000000 1
1 00000710 00000000 2 a5a501c4 00000000 1
2 00000801 000000ee 0 00000000 00000000 0
2 00000802 00001234 1 00000000 00000000 0
2 00000800 00000077 0 00000000 00000000 0
1 00000800 00000000 2 1234ee77 00000000 1
2 00000804 cafef00d 2 00000000 00000000 0
1 00000804 00000000 2 cafef00d 00000000 1
4 02000000 00000000 2 00000000 00000000 0
4 02000000 00000000 2 00000000 00000000 0
4 02000004 00000000 2 00000000 00000000 0
5 000000c0 00000900 2 a5a50030 a5a50240 2
5 000000c4 00000906 1 a5a50031 ffffa5a5 2

//--- bench/tb_clock.sv
module tb_clock (
	output logic clock,
	output logic rst_n
);

	logic rst_q = 1'b0;
	logic [2:0] edges = 3'd0;

	assign rst_n = rst_q;

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// Reset is seen low by the first four rising edges.
	always @(posedge clock) begin
		if (edges == 3'd3) begin
			rst_q <= 1'b1;
		end
		if (edges != 3'd7) begin
			edges <= edges + 3'd1;
		end
	end

endmodule

//--- bench/tb_mem_subsys.sv
module tb_mem_subsys;

	localparam int max_lines = 64;
	localparam int fields = 7;

	logic clock;
	logic rst_n;
	logic fetch_valid;
	logic fetch_ready;
	logic [31:0] fetch_pc;
	logic [31:0] fetch_inst;
	logic inst_valid;
	logic fence_i;
	logic lsu_valid;
	logic lsu_ready;
	mem_pkg::lsu_req_t lsu_req;
	logic [31:0] wb_val;
	logic wb_valid;
	mem_pkg::ar_t m_ar;
	logic m_ar_valid;
	logic m_ar_ready;
	mem_pkg::r_t m_r = '0;
	logic m_r_valid = 1'b0;
	logic m_r_ready;
	mem_pkg::aw_t m_aw;
	logic m_aw_valid;
	logic m_aw_ready;
	mem_pkg::w_t m_w;
	logic m_w_valid;
	logic m_w_ready;
	mem_pkg::b_t m_b = '0;
	logic m_b_valid = 1'b0;
	logic m_b_ready;

	logic [31:0] mem [1024];
	logic rd_busy = 1'b0;
	logic [2:0] rd_wait;
	logic [9:0] rd_idx;
	logic [2:0] ar_size_q;
	logic aw_got = 1'b0;
	logic w_got = 1'b0;
	logic [2:0] wr_wait;
	logic [9:0] wr_idx;
	logic [2:0] aw_size_q;
	mem_pkg::w_t w_q;
	int ar_count = 0;

	logic [31:0] stim [max_lines*fields];
	int lines = 0;
	int limit = 0;
	int cycles = 0;
	int errors = 0;

	tb_clock clock_gen (.clock(clock), .rst_n(rst_n));

	mem_subsys dut (.*);

	function automatic logic [2:0] draw_delay();
		return 3'(($urandom % 32'd4) + 32'd1);
	endfunction

	// AXI size is log2 of the access width in bytes.
	function automatic logic [2:0] access_size(input logic [2:0] funct3);
		case (funct3[1:0])
			2'b00: return mem_pkg::size_byte;
			2'b01: return mem_pkg::size_half;
			default: return mem_pkg::size_word;
		endcase
	endfunction

	// Read side of the memory model.
	assign m_ar_ready = !rd_busy;

	always @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rd_busy <= 1'b0;
			m_r_valid <= 1'b0;
			ar_count <= 0;
		end else if (m_ar_valid && m_ar_ready) begin
			rd_busy <= 1'b1;
			rd_idx <= m_ar.addr[11:2];
			ar_size_q <= m_ar.size;
			rd_wait <= draw_delay();
			ar_count <= ar_count + 1;
		end else if (rd_busy && !m_r_valid) begin
			if (rd_wait <= 3'd1) begin
				m_r_valid <= 1'b1;
				m_r <= '{data: mem[rd_idx], resp: 2'b00, last: 1'b1};
			end else begin
				rd_wait <= rd_wait - 3'd1;
			end
		end else if (m_r_valid && m_r_ready) begin
			m_r_valid <= 1'b0;
			rd_busy <= 1'b0;
		end
	end

	// Write side of the memory model. Strobed bytes land when b is raised.
	assign m_aw_ready = !aw_got;
	assign m_w_ready = !w_got;

	always @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			aw_got <= 1'b0;
			w_got <= 1'b0;
			m_b_valid <= 1'b0;
			m_b <= '0;
			for (int i = 0; i < 1024; i++) begin
				mem[i] <= 32'(i) ^ 32'ha5a5_0000;
			end
		end else begin
			if (m_aw_valid && m_aw_ready) begin
				aw_got <= 1'b1;
				wr_idx <= m_aw.addr[11:2];
				aw_size_q <= m_aw.size;
				wr_wait <= draw_delay();
			end
			if (m_w_valid && m_w_ready) begin
				w_got <= 1'b1;
				w_q <= m_w;
			end
			if (aw_got && w_got && !m_b_valid) begin
				if (wr_wait <= 3'd1) begin
					m_b_valid <= 1'b1;
					for (int lane = 0; lane < 4; lane++) begin
						if (w_q.strb[lane]) begin
							mem[wr_idx][8*lane +: 8] <= w_q.data[8*lane +: 8];
						end
					end
				end else begin
					wr_wait <= wr_wait - 3'd1;
				end
			end
			if (m_b_valid && m_b_ready) begin
				m_b_valid <= 1'b0;
				aw_got <= 1'b0;
				w_got <= 1'b0;
			end
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout: tests still running after %0d cycles", limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic fetch_word(input logic [31:0] pc, output logic [31:0] inst);
		@(posedge clock);
		fetch_valid <= 1'b1;
		fetch_pc <= pc;
		do begin
			@(posedge clock);
		end while (!fetch_ready);
		fetch_valid <= 1'b0;
		do begin
			@(posedge clock);
		end while (!inst_valid);
		inst = fetch_inst;
	endtask

	task automatic lsu_access(input logic [31:0] addr, input logic [31:0] wdata,
		input logic [2:0] funct3, input logic wen, output logic [31:0] result);
		mem_pkg::lsu_req_t req;
		req.addr = addr;
		req.wdata = wdata;
		req.funct3 = funct3;
		req.wen = wen;
		@(posedge clock);
		lsu_valid <= 1'b1;
		lsu_req <= req;
		do begin
			@(posedge clock);
		end while (!lsu_ready);
		lsu_valid <= 1'b0;
		do begin
			@(posedge clock);
		end while (!wb_valid);
		result = wb_val;
	endtask

	task automatic pulse_fence();
		@(posedge clock);
		fence_i <= 1'b1;
		@(posedge clock);
		fence_i <= 1'b0;
	endtask

	initial begin
		int seed;
		int errors_before;
		int ar_before;
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] funct3;
		logic [31:0] exp_a;
		logic [31:0] exp_b;
		logic [31:0] exp_ar;
		logic [2:0] exp_size;
		logic [31:0] got_a;
		logic [31:0] got_b;
		logic [31:0] last_lo;
		seed = $urandom(20728);
		fetch_valid = 1'b0;
		fetch_pc = '0;
		fence_i = 1'b0;
		lsu_valid = 1'b0;
		lsu_req = '0;
		last_lo = '0;
		for (int i = 0; i < max_lines*fields; i++) begin
			stim[i] = 32'hffff_ffff;
		end
		$readmemh("bench/mem_stim.txt", stim);
		while (lines < max_lines && stim[lines*fields] != 32'hffff_ffff) begin
			lines++;
		end
		limit = lines * 40;
		if (lines == 0) begin
			$display("No test operations could be read from the stimulus file");
			errors++;
		end
		wait (rst_n === 1'b1);
		for (int t = 0; t < lines; t++) begin
			op = stim[t*fields];
			addr = stim[t*fields + 1];
			data = stim[t*fields + 2];
			funct3 = stim[t*fields + 3];
			exp_a = stim[t*fields + 4];
			exp_b = stim[t*fields + 5];
			exp_ar = stim[t*fields + 6];
			exp_size = access_size(funct3[2:0]);
			errors_before = errors;
			ar_before = ar_count;
			case (op)
				32'd0: begin
					fetch_word(addr, got_a);
					if (got_a !== exp_a) begin
						$display("[FAIL] test %0d fetch_inst got %h expected %h", t, got_a, exp_a);
						errors++;
					end
					if (ar_count != ar_before && ar_size_q !== mem_pkg::size_word) begin
						$display("[FAIL] test %0d m_ar.size got %h expected %h", t,
							ar_size_q, mem_pkg::size_word);
						errors++;
					end
				end
				32'd1, 32'd2: begin
					lsu_access(addr, data, funct3[2:0], op == 32'd2, got_a);
					if (got_a !== exp_a) begin
						$display("[FAIL] test %0d wb_val got %h expected %h", t, got_a, exp_a);
						errors++;
					end
					if (op == 32'd1 && ar_size_q !== exp_size) begin
						$display("[FAIL] test %0d m_ar.size got %h expected %h", t,
							ar_size_q, exp_size);
						errors++;
					end
					if (op == 32'd2 && aw_size_q !== exp_size) begin
						$display("[FAIL] test %0d m_aw.size got %h expected %h", t,
							aw_size_q, exp_size);
						errors++;
					end
					if (op == 32'd2 && w_q.last !== 1'b1) begin
						$display("[FAIL] test %0d m_w.last got %h expected 1", t, w_q.last);
						errors++;
					end
				end
				32'd3: pulse_fence();
				32'd4: begin
					lsu_access(addr, 32'd0, funct3[2:0], 1'b0, got_a);
					// High word is exact; low word must keep counting up.
					if (addr[2] && got_a !== exp_a) begin
						$display("[FAIL] test %0d wb_val got %h expected %h", t, got_a, exp_a);
						errors++;
					end
					if (!addr[2] && (got_a == 32'd0 || got_a <= last_lo)) begin
						$display("[FAIL] test %0d wb_val got %h not above %h", t, got_a, last_lo);
						errors++;
					end
					if (!addr[2]) begin
						last_lo = got_a;
					end
				end
				32'd5: begin
					fork
						fetch_word(addr, got_a);
						lsu_access(data, 32'd0, funct3[2:0], 1'b0, got_b);
					join
					if (got_a !== exp_a) begin
						$display("[FAIL] test %0d fetch_inst got %h expected %h", t, got_a, exp_a);
						errors++;
					end
					if (got_b !== exp_b) begin
						$display("[FAIL] test %0d wb_val got %h expected %h", t, got_b, exp_b);
						errors++;
					end
				end
				default: begin
					$display("Test %0d has an unknown operation code %0d", t, op);
					errors++;
				end
			endcase
			if (ar_count - ar_before != int'(exp_ar)) begin
				$display("[FAIL] test %0d m_ar transfers got %h expected %h", t,
					ar_count - ar_before, exp_ar);
				errors++;
			end
			$display("test %0d op %0d addr %h %s", t, op, addr,
				(errors == errors_before) ? "ok" : "error");
		end
		$display("tests run %0d, failed checks %0d", lines, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- common/mem_pkg.sv
package mem_pkg;

	localparam int addr_width = 32;
	localparam int data_width = 32;

	// Direct-mapped, one word per line.
	localparam int icache_lines = 16;
	localparam int icache_index_bits = 4;
	localparam int icache_tag_bits = addr_width - icache_index_bits - 2;

	// Timer window and its register offsets.
	localparam logic [addr_width-1:0] clint_base = 32'h0200_0000;
	localparam logic [addr_width-1:0] clint_mask = 32'hffff_0000;
	localparam logic [addr_width-1:0] clint_mtime_lo = 32'h0000_0000;
	localparam logic [addr_width-1:0] clint_mtime_hi = 32'h0000_0004;

	localparam logic [2:0] size_byte = 3'd0;
	localparam logic [2:0] size_half = 3'd1;
	localparam logic [2:0] size_word = 3'd2;

	localparam logic [2:0] funct3_lb = 3'b000;
	localparam logic [2:0] funct3_lh = 3'b001;
	localparam logic [2:0] funct3_lw = 3'b010;
	localparam logic [2:0] funct3_lbu = 3'b100;
	localparam logic [2:0] funct3_lhu = 3'b101;
	localparam logic [2:0] funct3_sb = 3'b000;
	localparam logic [2:0] funct3_sh = 3'b001;
	localparam logic [2:0] funct3_sw = 3'b010;

	typedef struct packed {
		logic [addr_width-1:0] addr;
		logic [2:0] size;
	} ar_t;

	typedef struct packed {
		logic [data_width-1:0] data;
		logic [1:0] resp;
		logic last;
	} r_t;

	typedef ar_t aw_t;

	typedef struct packed {
		logic [data_width-1:0] data;
		logic [data_width/8-1:0] strb;
		logic last;
	} w_t;

	typedef struct packed {
		logic [1:0] resp;
	} b_t;

	// Store when wen is high.
	typedef struct packed {
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] wdata;
		logic [2:0] funct3;
		logic wen;
	} lsu_req_t;

endpackage

//--- icache/icache.sv
module icache (
	input  logic clock,
	input  logic rst_n,
	input  logic fetch_valid,
	output logic fetch_ready,
	input  logic [31:0] fetch_pc,
	output logic [31:0] fetch_inst,
	output logic inst_valid,
	input  logic fence_i,
	output mem_pkg::ar_t ar,
	output logic ar_valid,
	input  logic ar_ready,
	input  mem_pkg::r_t r,
	input  logic r_valid,
	output logic r_ready
);

	typedef enum logic [1:0] {
		idle,
		lookup,
		request,
		refill
	} state_t;

	state_t state;
	logic [31:0] pc_q;
	logic [mem_pkg::icache_lines-1:0] line_valid;
	logic [mem_pkg::icache_tag_bits-1:0] tags [mem_pkg::icache_lines];
	logic [31:0] lines [mem_pkg::icache_lines];
	logic [mem_pkg::icache_index_bits-1:0] index;
	logic [mem_pkg::icache_tag_bits-1:0] tag;
	logic hit;
	logic flush_seen;

	assign index = pc_q[mem_pkg::icache_index_bits+1:2];
	assign tag = pc_q[31:mem_pkg::icache_index_bits+2];
	assign hit = line_valid[index] && (tags[index] == tag);

	assign fetch_ready = (state == idle);
	assign inst_valid = ((state == lookup) && hit) || ((state == refill) && r_valid);
	// Refill data goes straight out in the cycle it arrives.
	assign fetch_inst = (state == refill) ? r.data : lines[index];

	assign ar.addr = {pc_q[31:2], 2'b00};
	assign ar.size = mem_pkg::size_word;
	assign ar_valid = (state == request);
	assign r_ready = (state == refill);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			line_valid <= '0;
			flush_seen <= 1'b0;
		end else begin
			// A fence during a miss leaves the refilled line invalid.
			flush_seen <= (state != idle) && (flush_seen || fence_i);
			if (fence_i) begin
				line_valid <= '0;
			end
			case (state)
				idle: begin
					if (fetch_valid) begin
						state <= lookup;
					end
				end
				lookup: begin
					state <= hit ? idle : request;
				end
				request: begin
					if (ar_ready) begin
						state <= refill;
					end
				end
				refill: begin
					if (r_valid) begin
						state <= idle;
						if (!fence_i && !flush_seen) begin
							line_valid[index] <= 1'b1;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_valid && fetch_ready) begin
			pc_q <= fetch_pc;
		end
		if ((state == refill) && r_valid) begin
			tags[index] <= tag;
			lines[index] <= r.data;
		end
	end

endmodule

//--- logic/clint.sv
module clint (
	input  logic clock,
	input  logic rst_n,
	input  mem_pkg::ar_t ar,
	input  logic ar_valid,
	output logic ar_ready,
	output mem_pkg::r_t r,
	output logic r_valid,
	input  logic r_ready
);

	logic [63:0] mtime;
	logic [31:0] offset;
	logic [31:0] word;
	logic [31:0] rdata_q;

	// Only bit 2 selects the word.
	assign offset = {29'd0, ar.addr[2], 2'b00};

	always_comb begin
		case (offset)
			mem_pkg::clint_mtime_hi: word = mtime[63:32];
			mem_pkg::clint_mtime_lo: word = mtime[31:0];
			default: word = mtime[31:0];
		endcase
	end

	assign ar_ready = !r_valid;
	assign r.data = rdata_q;
	assign r.resp = 2'b00;
	assign r.last = 1'b1;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
			r_valid <= 1'b0;
		end else begin
			mtime <= mtime + 64'd1;
			if (ar_valid && ar_ready) begin
				r_valid <= 1'b1;
			end else if (r_ready) begin
				r_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ar_valid && ar_ready) begin
			rdata_q <= word;
		end
	end

endmodule

//--- logic/mem_subsys.sv
module mem_subsys (
	input  logic clock,
	input  logic rst_n,
	input  logic fetch_valid,
	output logic fetch_ready,
	input  logic [31:0] fetch_pc,
	output logic [31:0] fetch_inst,
	output logic inst_valid,
	input  logic fence_i,
	input  logic lsu_valid,
	output logic lsu_ready,
	input  mem_pkg::lsu_req_t lsu_req,
	output logic [31:0] wb_val,
	output logic wb_valid,
	output mem_pkg::ar_t m_ar,
	output logic m_ar_valid,
	input  logic m_ar_ready,
	input  mem_pkg::r_t m_r,
	input  logic m_r_valid,
	output logic m_r_ready,
	output mem_pkg::aw_t m_aw,
	output logic m_aw_valid,
	input  logic m_aw_ready,
	output mem_pkg::w_t m_w,
	output logic m_w_valid,
	input  logic m_w_ready,
	input  mem_pkg::b_t m_b,
	input  logic m_b_valid,
	output logic m_b_ready
);

	mem_pkg::ar_t ic_ar;
	logic ic_ar_valid;
	logic ic_ar_ready;
	mem_pkg::r_t ic_r;
	logic ic_r_valid;
	logic ic_r_ready;
	mem_pkg::ar_t ls_ar;
	logic ls_ar_valid;
	logic ls_ar_ready;
	mem_pkg::r_t ls_r;
	logic ls_r_valid;
	logic ls_r_ready;
	mem_pkg::aw_t ls_aw;
	logic ls_aw_valid;
	logic ls_aw_ready;
	mem_pkg::w_t ls_w;
	logic ls_w_valid;
	logic ls_w_ready;
	mem_pkg::b_t ls_b;
	logic ls_b_valid;
	logic ls_b_ready;
	mem_pkg::ar_t clint_ar;
	logic clint_ar_valid;
	logic clint_ar_ready;
	mem_pkg::r_t clint_r;
	logic clint_r_valid;
	logic clint_r_ready;

	icache u_icache (
		.clock(clock), .rst_n(rst_n),
		.fetch_valid(fetch_valid), .fetch_ready(fetch_ready), .fetch_pc(fetch_pc),
		.fetch_inst(fetch_inst), .inst_valid(inst_valid), .fence_i(fence_i),
		.ar(ic_ar), .ar_valid(ic_ar_valid), .ar_ready(ic_ar_ready),
		.r(ic_r), .r_valid(ic_r_valid), .r_ready(ic_r_ready)
	);

	lsu u_lsu (
		.clock(clock), .rst_n(rst_n),
		.req_valid(lsu_valid), .req_ready(lsu_ready), .req(lsu_req),
		.wb_val(wb_val), .wb_valid(wb_valid),
		.ar(ls_ar), .ar_valid(ls_ar_valid), .ar_ready(ls_ar_ready),
		.r(ls_r), .r_valid(ls_r_valid), .r_ready(ls_r_ready),
		.aw(ls_aw), .aw_valid(ls_aw_valid), .aw_ready(ls_aw_ready),
		.w(ls_w), .w_valid(ls_w_valid), .w_ready(ls_w_ready),
		.b(ls_b), .b_valid(ls_b_valid), .b_ready(ls_b_ready)
	);

	xbar u_xbar (
		.clock(clock), .rst_n(rst_n),
		.ic_ar(ic_ar), .ic_ar_valid(ic_ar_valid), .ic_ar_ready(ic_ar_ready),
		.ic_r(ic_r), .ic_r_valid(ic_r_valid), .ic_r_ready(ic_r_ready),
		.ls_ar(ls_ar), .ls_ar_valid(ls_ar_valid), .ls_ar_ready(ls_ar_ready),
		.ls_r(ls_r), .ls_r_valid(ls_r_valid), .ls_r_ready(ls_r_ready),
		.ls_aw(ls_aw), .ls_aw_valid(ls_aw_valid), .ls_aw_ready(ls_aw_ready),
		.ls_w(ls_w), .ls_w_valid(ls_w_valid), .ls_w_ready(ls_w_ready),
		.ls_b(ls_b), .ls_b_valid(ls_b_valid), .ls_b_ready(ls_b_ready),
		.clint_ar(clint_ar), .clint_ar_valid(clint_ar_valid),
		.clint_ar_ready(clint_ar_ready),
		.clint_r(clint_r), .clint_r_valid(clint_r_valid), .clint_r_ready(clint_r_ready),
		.m_ar(m_ar), .m_ar_valid(m_ar_valid), .m_ar_ready(m_ar_ready),
		.m_r(m_r), .m_r_valid(m_r_valid), .m_r_ready(m_r_ready),
		.m_aw(m_aw), .m_aw_valid(m_aw_valid), .m_aw_ready(m_aw_ready),
		.m_w(m_w), .m_w_valid(m_w_valid), .m_w_ready(m_w_ready),
		.m_b(m_b), .m_b_valid(m_b_valid), .m_b_ready(m_b_ready)
	);

	clint u_clint (
		.clock(clock), .rst_n(rst_n),
		.ar(clint_ar), .ar_valid(clint_ar_valid), .ar_ready(clint_ar_ready),
		.r(clint_r), .r_valid(clint_r_valid), .r_ready(clint_r_ready)
	);

endmodule

//--- lsu/lsu.sv
module lsu (
	input  logic clock,
	input  logic rst_n,
	input  logic req_valid,
	output logic req_ready,
	input  mem_pkg::lsu_req_t req,
	output logic [31:0] wb_val,
	output logic wb_valid,
	output mem_pkg::ar_t ar,
	output logic ar_valid,
	input  logic ar_ready,
	input  mem_pkg::r_t r,
	input  logic r_valid,
	output logic r_ready,
	output mem_pkg::aw_t aw,
	output logic aw_valid,
	input  logic aw_ready,
	output mem_pkg::w_t w,
	output logic w_valid,
	input  logic w_ready,
	input  mem_pkg::b_t b,
	input  logic b_valid,
	output logic b_ready
);

	typedef enum logic [2:0] {
		idle,
		read_addr,
		read_data,
		write_req,
		write_resp
	} state_t;

	state_t state;
	mem_pkg::lsu_req_t req_q;
	logic aw_done;
	logic w_done;
	logic aw_fire;
	logic w_fire;
	logic [1:0] offset;
	logic [4:0] shift;
	logic [2:0] size;
	logic [3:0] strb;
	logic [31:0] rdata;
	logic [31:0] load_val;

	assign offset = req_q.addr[1:0];
	assign shift = {offset, 3'b000};

	always_comb begin
		case (req_q.funct3[1:0])
			mem_pkg::funct3_sb[1:0]: size = mem_pkg::size_byte;
			mem_pkg::funct3_sh[1:0]: size = mem_pkg::size_half;
			mem_pkg::funct3_sw[1:0]: size = mem_pkg::size_word;
			default: size = mem_pkg::size_word;
		endcase
		case (size)
			mem_pkg::size_byte: strb = 4'b0001 << offset;
			mem_pkg::size_half: strb = 4'b0011 << offset;
			default: strb = 4'b1111;
		endcase
	end

	// Addressed byte or half moved down to bit 0.
	assign rdata = r.data >> shift;

	always_comb begin
		case (req_q.funct3)
			mem_pkg::funct3_lb: load_val = {{24{rdata[7]}}, rdata[7:0]};
			mem_pkg::funct3_lh: load_val = {{16{rdata[15]}}, rdata[15:0]};
			mem_pkg::funct3_lbu: load_val = {24'd0, rdata[7:0]};
			mem_pkg::funct3_lhu: load_val = {16'd0, rdata[15:0]};
			mem_pkg::funct3_lw: load_val = rdata;
			default: load_val = rdata;
		endcase
	end

	assign ar.addr = req_q.addr;
	assign ar.size = size;
	assign aw.addr = req_q.addr;
	assign aw.size = size;
	assign w.data = req_q.wdata << shift;
	assign w.strb = strb;
	assign w.last = 1'b1;

	assign req_ready = (state == idle);
	assign ar_valid = (state == read_addr);
	assign r_ready = (state == read_data);
	assign aw_valid = (state == write_req) && !aw_done;
	assign w_valid = (state == write_req) && !w_done;
	assign b_ready = (state == write_resp);
	assign aw_fire = aw_valid && aw_ready;
	assign w_fire = w_valid && w_ready;

	assign wb_valid = ((state == read_data) && r_valid) || ((state == write_resp) && b_valid);
	// Stores write back their response code.
	assign wb_val = req_q.wen ? {30'd0, b.resp} : load_val;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			aw_done <= 1'b0;
			w_done <= 1'b0;
		end else begin
			case (state)
				idle: begin
					aw_done <= 1'b0;
					w_done <= 1'b0;
					if (req_valid) begin
						state <= req.wen ? write_req : read_addr;
					end
				end
				read_addr: if (ar_ready) state <= read_data;
				read_data: if (r_valid) state <= idle;
				write_req: begin
					aw_done <= aw_done || aw_fire;
					w_done <= w_done || w_fire;
					if ((aw_done || aw_fire) && (w_done || w_fire)) begin
						state <= write_resp;
					end
				end
				write_resp: if (b_valid) state <= idle;
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (req_valid && req_ready) begin
			req_q <= req;
		end
	end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -j 0 --top-module tb_mem_subsys -f tb.f -o tb_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$log"; then
	exit 1
fi
if ! grep -q "SIMULATION PASSED" "$log"; then
	echo "No pass line found in $log"
	exit 1
fi
exit 0

//--- tb.f
common/mem_pkg.sv
icache/icache.sv
lsu/lsu.sv
xbar/xbar.sv
logic/clint.sv
logic/mem_subsys.sv
bench/tb_clock.sv
bench/tb_mem_subsys.sv

//--- xbar/xbar.sv
module xbar (
	input  logic clock,
	input  logic rst_n,
	input  mem_pkg::ar_t ic_ar,
	input  logic ic_ar_valid,
	output logic ic_ar_ready,
	output mem_pkg::r_t ic_r,
	output logic ic_r_valid,
	input  logic ic_r_ready,
	input  mem_pkg::ar_t ls_ar,
	input  logic ls_ar_valid,
	output logic ls_ar_ready,
	output mem_pkg::r_t ls_r,
	output logic ls_r_valid,
	input  logic ls_r_ready,
	input  mem_pkg::aw_t ls_aw,
	input  logic ls_aw_valid,
	output logic ls_aw_ready,
	input  mem_pkg::w_t ls_w,
	input  logic ls_w_valid,
	output logic ls_w_ready,
	output mem_pkg::b_t ls_b,
	output logic ls_b_valid,
	input  logic ls_b_ready,
	output mem_pkg::ar_t clint_ar,
	output logic clint_ar_valid,
	input  logic clint_ar_ready,
	input  mem_pkg::r_t clint_r,
	input  logic clint_r_valid,
	output logic clint_r_ready,
	output mem_pkg::ar_t m_ar,
	output logic m_ar_valid,
	input  logic m_ar_ready,
	input  mem_pkg::r_t m_r,
	input  logic m_r_valid,
	output logic m_r_ready,
	output mem_pkg::aw_t m_aw,
	output logic m_aw_valid,
	input  logic m_aw_ready,
	output mem_pkg::w_t m_w,
	output logic m_w_valid,
	input  logic m_w_ready,
	input  mem_pkg::b_t m_b,
	input  logic m_b_valid,
	output logic m_b_ready
);

	typedef enum logic [1:0] {
		own_none,
		own_fetch,
		own_lsu
	} owner_t;

	typedef enum logic {
		to_master,
		to_timer
	} target_t;

	owner_t owner_q;
	owner_t owner;
	target_t target_q;
	target_t target;
	logic ar_done_q;
	mem_pkg::ar_t sel_ar;
	logic sel_valid;
	logic sel_ready;
	logic in_window;
	logic resp_valid;
	logic resp_ready;
	logic r_fire;

	// Load/store side wins a tie.
	always_comb begin
		owner = owner_q;
		if (owner_q == own_none) begin
			if (ls_ar_valid) begin
				owner = own_lsu;
			end else if (ic_ar_valid) begin
				owner = own_fetch;
			end
		end
	end

	assign sel_ar = (owner == own_lsu) ? ls_ar : ic_ar;
	assign sel_valid = !ar_done_q && (((owner == own_lsu) && ls_ar_valid) ||
		((owner == own_fetch) && ic_ar_valid));
	assign in_window = ((sel_ar.addr & mem_pkg::clint_mask) == mem_pkg::clint_base);
	assign target = (owner_q == own_none) ? (in_window ? to_timer : to_master) : target_q;

	assign m_ar = sel_ar;
	assign clint_ar = sel_ar;
	assign m_ar_valid = sel_valid && (target == to_master);
	assign clint_ar_valid = sel_valid && (target == to_timer);
	assign sel_ready = !ar_done_q && ((target == to_timer) ? clint_ar_ready : m_ar_ready);
	assign ls_ar_ready = (owner == own_lsu) && sel_ready;
	assign ic_ar_ready = (owner == own_fetch) && sel_ready;

	// Response path follows the registered owner and target.
	assign resp_valid = ar_done_q && ((target_q == to_timer) ? clint_r_valid : m_r_valid);
	assign resp_ready = ((owner_q == own_fetch) && ic_r_ready) ||
		((owner_q == own_lsu) && ls_r_ready);
	assign r_fire = resp_valid && resp_ready;

	assign ic_r = (target_q == to_timer) ? clint_r : m_r;
	assign ls_r = ic_r;
	assign ic_r_valid = resp_valid && (owner_q == own_fetch);
	assign ls_r_valid = resp_valid && (owner_q == own_lsu);
	assign m_r_ready = ar_done_q && (target_q == to_master) && resp_ready;
	assign clint_r_ready = ar_done_q && (target_q == to_timer) && resp_ready;

	assign m_aw = ls_aw;
	assign m_aw_valid = ls_aw_valid;
	assign ls_aw_ready = m_aw_ready;
	assign m_w = ls_w;
	assign m_w_valid = ls_w_valid;
	assign ls_w_ready = m_w_ready;
	assign ls_b = m_b;
	assign ls_b_valid = m_b_valid;
	assign m_b_ready = ls_b_ready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			owner_q <= own_none;
			target_q <= to_master;
			ar_done_q <= 1'b0;
		end else if (r_fire) begin
			owner_q <= own_none;
			ar_done_q <= 1'b0;
		end else begin
			if (owner_q == own_none) begin
				owner_q <= owner;
				target_q <= target;
			end
			if (sel_valid && sel_ready) begin
				ar_done_q <= 1'b1;
			end
		end
	end

endmodule
